// ==== sim/decode_golden.txt ====
# W addr data | F exv exdst exdata exload memv memdst memdata wbv wbaddr wbdata (next D only)
# D inst pc hold flush alu src2 gr_we dest mem_rd mem_wr rs_val rt_val taken target br_stall
W 01 11111111
W 02 22222222
W 03 80000000
W 04 00000004
W 05 00001000
W 06 11111111
W 07 7777aaaa
# r-type
D 00224021 00400000 0 0 0 0 1 08 0 0 11111111 22222222 0 00000000 0
D 00644823 00400004 0 0 1 0 1 09 0 0 80000000 00000004 0 00000000 0
D 0064502a 00400008 0 0 2 0 1 0a 0 0 80000000 00000004 0 00000000 0
D 0064582b 0040000c 0 0 3 0 1 0b 0 0 80000000 00000004 0 00000000 0
D 00226027 00400010 0 0 7 0 1 0c 0 0 11111111 22222222 0 00000000 0
D 00026900 00400014 0 0 8 0 1 0d 0 0 00000000 22222222 0 00000000 0
# immediates, lui, lw, sw and an opcode outside the subset
D 2427fff0 00400018 0 0 0 1 1 07 0 0 11111111 7777aaaa 0 00000000 0
D 304700ff 0040001c 0 0 4 2 1 07 0 0 22222222 7777aaaa 0 00000000 0
D 34861234 00400020 0 0 5 2 1 06 0 0 00000004 11111111 0 00000000 0
D 3c05abcd 00400024 0 0 b 1 1 05 0 0 00000000 00001000 0 00000000 0
D 8c270008 00400028 0 0 0 1 1 07 1 0 11111111 7777aaaa 0 00000000 0
D ac82fffc 0040002c 0 0 0 1 0 00 0 1 00000004 22222222 0 00000000 0
D 20010001 00400030 0 0 0 0 0 00 0 0 00000000 11111111 0 00000000 0
# forwarding priority
F 1 07 aaaa0007 0 1 07 bbbb0007 1 07 cccc0007
D 00e24021 00400034 0 0 0 0 1 08 0 0 aaaa0007 22222222 0 00000000 0
F 0 00 00000000 0 1 07 bbbb0007 1 07 cccc0007
D 00e24021 00400038 0 0 0 0 1 08 0 0 bbbb0007 22222222 0 00000000 0
F 0 00 00000000 0 0 00 00000000 1 07 cccc0077
D 00e24021 0040003c 0 0 0 0 1 08 0 0 cccc0077 22222222 0 00000000 0
F 1 00 deadbeef 0 1 00 feedface 1 00 01234567
D 00024021 00400040 0 0 0 0 1 08 0 0 00000000 22222222 0 00000000 0
# load-use
F 1 02 5555aaaa 1 0 00 00000000 0 00 00000000
D 00224823 00400044 3 0 1 0 1 09 0 0 11111111 5555aaaa 0 00000000 0
# branches and jumps
D 10260010 00400100 0 0 0 0 0 00 0 0 11111111 11111111 1 00400144 0
D 1422fff8 00400200 0 0 0 0 0 00 0 0 11111111 22222222 1 004001e4 0
D 14260004 00400300 0 0 0 0 0 00 0 0 11111111 11111111 0 00000000 0
D 08000400 1fc00010 0 0 0 0 0 00 0 0 00000000 00000000 1 10001000 0
D 0c000800 00400400 0 0 0 3 1 1f 0 0 00000000 00000000 1 00002000 0
D 00a00008 00400500 0 0 0 0 0 00 0 0 00001000 00000000 1 00001000 0
F 1 05 00002468 1 0 00 00000000 0 00 00000000
D 00a00008 00400600 2 0 0 0 0 00 0 0 00002468 00000000 1 00002468 1
# back-pressure, then flush
D 00224025 00400700 3 0 5 0 1 08 0 0 11111111 22222222 0 00000000 0
D 10260010 00400800 0 1 0 0 0 00 0 0 00000000 00000000 0 00000000 0

// ==== sources.f ====
design/decode_pkg.sv
design/inst_decoder.sv
design/reg_file.sv
design/operand_forward.sv
design/branch_resolve.sv
design/decode_stage.sv
sim/clock_gen.sv
sim/decode_stage_tb.sv

// ==== Bender.yml ====
package:
  name: decode_stage

sources:
  - design/decode_pkg.sv
  - design/inst_decoder.sv
  - design/reg_file.sv
  - design/operand_forward.sv
  - design/branch_resolve.sv
  - design/decode_stage.sv
  - target: simulation
    files:
      - sim/clock_gen.sv
      - sim/decode_stage_tb.sv

// ==== sim/decode_stage_tb.sv ====
`default_nettype none

module decode_stage_tb;

    localparam int drive_delay = 10;
    localparam int reset_cycles = 8;

    logic                  clk;
    logic                  reset;
    logic                  fs_to_ds_valid;
    decode_pkg::word_t     fs_inst;
    decode_pkg::word_t     fs_pc;
    logic                  es_allowin;
    logic                  flush;
    logic                  ex_fwd_valid;
    decode_pkg::reg_addr_t ex_fwd_dest;
    decode_pkg::word_t     ex_fwd_data;
    logic                  ex_fwd_is_load;
    logic                  mem_fwd_valid;
    decode_pkg::reg_addr_t mem_fwd_dest;
    decode_pkg::word_t     mem_fwd_data;
    logic                  wb_we;
    decode_pkg::reg_addr_t wb_addr;
    decode_pkg::word_t     wb_data;
    logic                  ds_allowin;
    logic                  ds_to_es_valid;
    decode_pkg::alu_op_e   alu_op;
    logic                  src1_is_sa;
    logic                  src1_is_pc;
    decode_pkg::src2_sel_e src2_sel;
    logic                  mem_read;
    logic                  mem_write;
    logic                  gr_we;
    decode_pkg::reg_addr_t dest;
    logic [15:0]           imm;
    decode_pkg::word_t     rs_value;
    decode_pkg::word_t     rt_value;
    decode_pkg::word_t     ds_pc;
    logic                  br_taken;
    logic                  br_stall;
    decode_pkg::word_t     br_target;

    // forwarding setup from the last F line
    logic [31:0] fwd_ex_valid, fwd_ex_dest, fwd_ex_data, fwd_ex_load;
    logic [31:0] fwd_mem_valid, fwd_mem_dest, fwd_mem_data;
    logic [31:0] fwd_wb_valid, fwd_wb_addr, fwd_wb_data;

    // current D line
    logic [31:0] case_inst, case_pc, case_hold, case_flush;
    logic [31:0] exp_alu, exp_src2, exp_gr_we, exp_dest, exp_mem_read, exp_mem_write;
    logic [31:0] exp_rs, exp_rt, exp_taken, exp_target, exp_br_stall;

    string golden[$];
    int    cycle_count = 0;
    int    cycle_limit = 0;
    int    case_count = 0;

    clock_gen clock_gen_i (
        .clk (clk)
    );

    decode_stage decode_stage_i (
        .clk            (clk),
        .reset          (reset),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_inst        (fs_inst),
        .fs_pc          (fs_pc),
        .es_allowin     (es_allowin),
        .flush          (flush),
        .ex_fwd_valid   (ex_fwd_valid),
        .ex_fwd_dest    (ex_fwd_dest),
        .ex_fwd_data    (ex_fwd_data),
        .ex_fwd_is_load (ex_fwd_is_load),
        .mem_fwd_valid  (mem_fwd_valid),
        .mem_fwd_dest   (mem_fwd_dest),
        .mem_fwd_data   (mem_fwd_data),
        .wb_we          (wb_we),
        .wb_addr        (wb_addr),
        .wb_data        (wb_data),
        .ds_allowin     (ds_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .alu_op         (alu_op),
        .src1_is_sa     (src1_is_sa),
        .src1_is_pc     (src1_is_pc),
        .src2_sel       (src2_sel),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .gr_we          (gr_we),
        .dest           (dest),
        .imm            (imm),
        .rs_value       (rs_value),
        .rt_value       (rt_value),
        .ds_pc          (ds_pc),
        .br_taken       (br_taken),
        .br_stall       (br_stall),
        .br_target      (br_target)
    );

    task automatic fail_run();
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("MISMATCH %s got %h expected %h", name, got, expected);
            fail_run();
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, decode never presented the case", cycle_count);
            fail_run();
        end
    end

    // unmatched stages carry random filler
    task automatic idle_forwarding();
        ex_fwd_valid   = 1'b0;
        ex_fwd_is_load = 1'b0;
        ex_fwd_dest    = 5'($urandom);
        ex_fwd_data    = $urandom;
        mem_fwd_valid  = 1'b0;
        mem_fwd_dest   = 5'($urandom);
        mem_fwd_data   = $urandom;
        wb_we          = 1'b0;
        wb_addr        = 5'($urandom);
        wb_data        = $urandom;
    endtask

    task automatic apply_forwarding();
        idle_forwarding();
        if (fwd_ex_valid != 0) begin
            ex_fwd_valid   = 1'b1;
            ex_fwd_dest    = fwd_ex_dest[4:0];
            ex_fwd_data    = fwd_ex_data;
            ex_fwd_is_load = fwd_ex_load != 0;
        end
        if (fwd_mem_valid != 0) begin
            mem_fwd_valid = 1'b1;
            mem_fwd_dest  = fwd_mem_dest[4:0];
            mem_fwd_data  = fwd_mem_data;
        end
        if (fwd_wb_valid != 0) begin
            wb_we   = 1'b1;
            wb_addr = fwd_wb_addr[4:0];
            wb_data = fwd_wb_data;
        end
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        @(posedge clk);
        #drive_delay;
        wb_we   = 1'b1;
        wb_addr = addr[4:0];
        wb_data = data;
        @(posedge clk);
        #drive_delay;
        idle_forwarding();
    endtask

    task automatic check_fields();
        logic shift_exp;
        logic link_exp;
        shift_exp = exp_alu == decode_pkg::alu_sll || exp_alu == decode_pkg::alu_srl ||
                    exp_alu == decode_pkg::alu_sra;
        // jal builds pc+8 from the pc and the constant
        link_exp = exp_src2 == decode_pkg::src2_8;
        check_value("ds_to_es_valid", ds_to_es_valid, 1);
        check_value("alu_op", alu_op, exp_alu);
        check_value("src1_is_sa", src1_is_sa, shift_exp);
        check_value("src1_is_pc", src1_is_pc, link_exp);
        check_value("src2_sel", src2_sel, exp_src2);
        check_value("imm", imm, case_inst[15:0]);
        check_value("gr_we", gr_we, exp_gr_we);
        if (exp_gr_we != 0) begin
            check_value("dest", dest, exp_dest);
        end
        check_value("mem_read", mem_read, exp_mem_read);
        check_value("mem_write", mem_write, exp_mem_write);
        check_value("rs_value", rs_value, exp_rs);
        check_value("rt_value", rt_value, exp_rt);
        check_value("ds_pc", ds_pc, case_pc);
        check_value("br_taken", br_taken, exp_taken);
        check_value("br_stall", br_stall, 0);
        if (exp_taken != 0) begin
            check_value("br_target", br_target, exp_target);
        end
    endtask

    task automatic run_case();
        int   i;
        logic load_stall;
        load_stall = fwd_ex_valid != 0 && fwd_ex_load != 0;
        @(posedge clk);
        #drive_delay;
        fs_to_ds_valid = 1'b1;
        fs_inst        = case_inst;
        fs_pc          = case_pc;
        do begin
            @(negedge clk);
        end while (ds_allowin !== 1'b1);
        @(posedge clk);
        #drive_delay;
        // decode register now holds the case
        fs_to_ds_valid = 1'b0;
        apply_forwarding();
        flush      = case_flush != 0;
        es_allowin = !(case_hold > 0 && !load_stall);
        for (i = 0; i < case_hold; i++) begin
            @(negedge clk);
            check_value("ds_allowin", ds_allowin, 0);
            if (load_stall) begin
                check_value("ds_to_es_valid", ds_to_es_valid, 0);
                check_value("br_stall", br_stall, exp_br_stall);
            end else begin
                check_fields();
            end
            @(posedge clk);
            #drive_delay;
        end
        if (load_stall) begin
            // load moves on to memory with its data
            mem_fwd_valid  = 1'b1;
            mem_fwd_dest   = ex_fwd_dest;
            mem_fwd_data   = ex_fwd_data;
            ex_fwd_valid   = 1'b0;
            ex_fwd_is_load = 1'b0;
        end
        es_allowin = 1'b1;
        @(negedge clk);
        if (case_flush != 0) begin
            check_value("ds_to_es_valid", ds_to_es_valid, 0);
            check_value("br_taken", br_taken, 0);
            check_value("br_stall", br_stall, 0);
        end else begin
            while (ds_to_es_valid !== 1'b1) begin
                @(negedge clk);
            end
            check_fields();
        end
        @(posedge clk);
        #drive_delay;
        flush = 1'b0;
        idle_forwarding();
        fwd_ex_valid  = 0;
        fwd_ex_load   = 0;
        fwd_mem_valid = 0;
        fwd_wb_valid  = 0;
        case_count++;
    endtask

    initial begin
        int          fd;
        int          n;
        int          seed_value;
        string       line;
        byte         tag;
        logic [31:0] w_addr;
        logic [31:0] w_data;
        seed_value     = $urandom(50255);
        reset          = 1'b1;
        fs_to_ds_valid = 1'b0;
        fs_inst        = '0;
        fs_pc          = '0;
        es_allowin     = 1'b1;
        flush          = 1'b0;
        fwd_ex_valid   = 0;
        fwd_ex_load    = 0;
        fwd_mem_valid  = 0;
        fwd_wb_valid   = 0;
        idle_forwarding();

        fd = $fopen("sim/decode_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open sim/decode_golden.txt");
            fail_run();
        end
        while (!$feof(fd)) begin
            if ($fgets(line, fd) > 0) begin
                golden.push_back(line);
            end
        end
        $fclose(fd);
        cycle_limit = 4 * golden.size() + 50;

        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        reset = 1'b0;
        @(negedge clk);
        check_value("ds_to_es_valid", ds_to_es_valid, 0);
        check_value("br_taken", br_taken, 0);
        check_value("br_stall", br_stall, 0);
        check_value("ds_allowin", ds_allowin, 1);

        foreach (golden[i]) begin
            tag = golden[i].getc(0);
            if (tag == "W") begin
                n = $sscanf(golden[i], "W %h %h", w_addr, w_data);
                if (n != 2) begin
                    $display("bad register preload line: %s", golden[i]);
                    fail_run();
                end else begin
                    write_reg(w_addr, w_data);
                end
            end else if (tag == "F") begin
                n = $sscanf(golden[i], "F %h %h %h %h %h %h %h %h %h %h",
                            fwd_ex_valid, fwd_ex_dest, fwd_ex_data, fwd_ex_load,
                            fwd_mem_valid, fwd_mem_dest, fwd_mem_data,
                            fwd_wb_valid, fwd_wb_addr, fwd_wb_data);
                if (n != 10) begin
                    $display("bad forwarding line: %s", golden[i]);
                    fail_run();
                end
            end else if (tag == "D") begin
                n = $sscanf(golden[i], "D %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            case_inst, case_pc, case_hold, case_flush,
                            exp_alu, exp_src2, exp_gr_we, exp_dest,
                            exp_mem_read, exp_mem_write, exp_rs, exp_rt,
                            exp_taken, exp_target, exp_br_stall);
                if (n != 15) begin
                    $display("bad decode case line: %s", golden[i]);
                    fail_run();
                end else begin
                    run_case();
                end
            end
        end

        if (case_count == 0) begin
            $display("the golden file holds no decode cases");
            fail_run();
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== sim/clock_gen.sv ====
`default_nettype none

module clock_gen #(
    parameter int period = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// ==== design/decode_stage.sv ====
`default_nettype none

module decode_stage (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   fs_to_ds_valid,
    input  decode_pkg::word_t     fs_inst,
    input  decode_pkg::word_t     fs_pc,
    input  wire                   es_allowin,
    input  wire                   flush,
    input  wire                   ex_fwd_valid,
    input  decode_pkg::reg_addr_t ex_fwd_dest,
    input  decode_pkg::word_t     ex_fwd_data,
    input  wire                   ex_fwd_is_load,
    input  wire                   mem_fwd_valid,
    input  decode_pkg::reg_addr_t mem_fwd_dest,
    input  decode_pkg::word_t     mem_fwd_data,
    input  wire                   wb_we,
    input  decode_pkg::reg_addr_t wb_addr,
    input  decode_pkg::word_t     wb_data,
    output logic                  ds_allowin,
    output logic                  ds_to_es_valid,
    output decode_pkg::alu_op_e   alu_op,
    output logic                  src1_is_sa,
    output logic                  src1_is_pc,
    output decode_pkg::src2_sel_e src2_sel,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic                  gr_we,
    output decode_pkg::reg_addr_t dest,
    output logic [decode_pkg::imm_w-1:0] imm,
    output decode_pkg::word_t     rs_value,
    output decode_pkg::word_t     rt_value,
    output decode_pkg::word_t     ds_pc,
    output logic                  br_taken,
    output logic                  br_stall,
    output decode_pkg::word_t     br_target
);

    logic                  ds_valid;
    decode_pkg::word_t     ds_inst;
    decode_pkg::reg_addr_t rs, rt;
    logic                  rs_used, rt_used;
    logic                  is_branch, is_jump, is_jump_reg, br_kind;
    decode_pkg::word_t     jump_target;
    decode_pkg::word_t     rf_rdata1, rf_rdata2;
    logic                  load_use_stall;
    logic                  taken;

    // handshake
    assign ds_allowin     = !ds_valid || (!load_use_stall && es_allowin);
    assign ds_to_es_valid = ds_valid && !load_use_stall && !flush;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_inst <= fs_inst;
            ds_pc   <= fs_pc;
        end
    end

    inst_decoder inst_decoder_i (
        .inst        (ds_inst),
        .pc          (ds_pc),
        .rs          (rs),
        .rt          (rt),
        .rs_used     (rs_used),
        .rt_used     (rt_used),
        .alu_op      (alu_op),
        .src1_is_sa  (src1_is_sa),
        .src1_is_pc  (src1_is_pc),
        .src2_sel    (src2_sel),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .gr_we       (gr_we),
        .dest        (dest),
        .imm         (imm),
        .is_branch   (is_branch),
        .is_jump     (is_jump),
        .is_jump_reg (is_jump_reg),
        .br_kind     (br_kind),
        .jump_target (jump_target)
    );

    reg_file reg_file_i (
        .clk    (clk),
        .raddr1 (rs),
        .raddr2 (rt),
        .we     (wb_we),
        .waddr  (wb_addr),
        .wdata  (wb_data),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    operand_forward operand_forward_i (
        .rs             (rs),
        .rt             (rt),
        .rs_used        (rs_used),
        .rt_used        (rt_used),
        .ex_fwd_valid   (ex_fwd_valid),
        .ex_fwd_dest    (ex_fwd_dest),
        .ex_fwd_data    (ex_fwd_data),
        .ex_fwd_is_load (ex_fwd_is_load),
        .mem_fwd_valid  (mem_fwd_valid),
        .mem_fwd_dest   (mem_fwd_dest),
        .mem_fwd_data   (mem_fwd_data),
        .wb_we          (wb_we),
        .wb_addr        (wb_addr),
        .wb_data        (wb_data),
        .rf_rdata1      (rf_rdata1),
        .rf_rdata2      (rf_rdata2),
        .rs_value       (rs_value),
        .rt_value       (rt_value),
        .load_use_stall (load_use_stall)
    );

    branch_resolve branch_resolve_i (
        .pc          (ds_pc),
        .imm         (imm),
        .rs_value    (rs_value),
        .rt_value    (rt_value),
        .is_branch   (is_branch),
        .is_jump     (is_jump),
        .is_jump_reg (is_jump_reg),
        .br_kind     (br_kind),
        .jump_target (jump_target),
        .taken       (taken),
        .target      (br_target)
    );

    // fetch holds off while a compare waits on a load
    assign br_stall = ds_valid && (is_branch || is_jump_reg) && load_use_stall && !flush;
    assign br_taken = ds_valid && taken && !flush;

endmodule

`default_nettype wire

// ==== design/branch_resolve.sv ====
`default_nettype none

module branch_resolve (
    input  decode_pkg::word_t     pc,
    input  wire [decode_pkg::imm_w-1:0] imm,
    input  decode_pkg::word_t     rs_value,
    input  decode_pkg::word_t     rt_value,
    input  wire                   is_branch,
    input  wire                   is_jump,
    input  wire                   is_jump_reg,
    input  wire                   br_kind,
    input  decode_pkg::word_t     jump_target,
    output logic                  taken,
    output decode_pkg::word_t     target
);

    decode_pkg::word_t seq_pc;
    decode_pkg::word_t br_offset;
    logic rs_eq_rt;

    assign seq_pc    = pc + 32'd4;
    assign br_offset = {{14{imm[15]}}, imm, 2'b00};
    assign rs_eq_rt  = rs_value == rt_value;

    // br_kind set means bne
    assign taken = is_jump || is_jump_reg ||
                   (is_branch && (br_kind ? !rs_eq_rt : rs_eq_rt));

    assign target = is_jump_reg ? rs_value :
                    is_jump     ? jump_target :
                                  seq_pc + br_offset;

endmodule

`default_nettype wire

// ==== design/operand_forward.sv ====
`default_nettype none

module operand_forward (
    input  decode_pkg::reg_addr_t rs,
    input  decode_pkg::reg_addr_t rt,
    input  wire                   rs_used,
    input  wire                   rt_used,
    input  wire                   ex_fwd_valid,
    input  decode_pkg::reg_addr_t ex_fwd_dest,
    input  decode_pkg::word_t     ex_fwd_data,
    input  wire                   ex_fwd_is_load,
    input  wire                   mem_fwd_valid,
    input  decode_pkg::reg_addr_t mem_fwd_dest,
    input  decode_pkg::word_t     mem_fwd_data,
    input  wire                   wb_we,
    input  decode_pkg::reg_addr_t wb_addr,
    input  decode_pkg::word_t     wb_data,
    input  decode_pkg::word_t     rf_rdata1,
    input  decode_pkg::word_t     rf_rdata2,
    output decode_pkg::word_t     rs_value,
    output decode_pkg::word_t     rt_value,
    output logic                  load_use_stall
);

    logic rs_ex_hit, rs_mem_hit, rs_wb_hit;
    logic rt_ex_hit, rt_mem_hit, rt_wb_hit;

    // $0 never matches, so it always falls through to the zero read
    function automatic logic src_hit(
        input decode_pkg::reg_addr_t src,
        input logic                  used,
        input logic                  valid,
        input decode_pkg::reg_addr_t dst
    );
        src_hit = used && valid && src == dst && src != 5'd0;
    endfunction

    assign rs_ex_hit  = src_hit(rs, rs_used, ex_fwd_valid, ex_fwd_dest);
    assign rs_mem_hit = src_hit(rs, rs_used, mem_fwd_valid, mem_fwd_dest);
    assign rs_wb_hit  = src_hit(rs, rs_used, wb_we, wb_addr);
    assign rt_ex_hit  = src_hit(rt, rt_used, ex_fwd_valid, ex_fwd_dest);
    assign rt_mem_hit = src_hit(rt, rt_used, mem_fwd_valid, mem_fwd_dest);
    assign rt_wb_hit  = src_hit(rt, rt_used, wb_we, wb_addr);

    // youngest producer wins
    assign rs_value = rs_ex_hit  ? ex_fwd_data :
                      rs_mem_hit ? mem_fwd_data :
                      rs_wb_hit  ? wb_data :
                                   rf_rdata1;
    assign rt_value = rt_ex_hit  ? ex_fwd_data :
                      rt_mem_hit ? mem_fwd_data :
                      rt_wb_hit  ? wb_data :
                                   rf_rdata2;

    // load data not ready until mem
    assign load_use_stall = ex_fwd_is_load && (rs_ex_hit || rt_ex_hit);

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`default_nettype none

module reg_file (
    input  wire                   clk,
    input  decode_pkg::reg_addr_t raddr1,
    input  decode_pkg::reg_addr_t raddr2,
    input  wire                   we,
    input  decode_pkg::reg_addr_t waddr,
    input  decode_pkg::word_t     wdata,
    output decode_pkg::word_t     rdata1,
    output decode_pkg::word_t     rdata2
);

    decode_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // $0 is hardwired
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== design/inst_decoder.sv ====
`default_nettype none

module inst_decoder (
    input  decode_pkg::word_t     inst,
    input  decode_pkg::word_t     pc,
    output decode_pkg::reg_addr_t rs,
    output decode_pkg::reg_addr_t rt,
    output logic                  rs_used,
    output logic                  rt_used,
    output decode_pkg::alu_op_e   alu_op,
    output logic                  src1_is_sa,
    output logic                  src1_is_pc,
    output decode_pkg::src2_sel_e src2_sel,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic                  gr_we,
    output decode_pkg::reg_addr_t dest,
    output logic [decode_pkg::imm_w-1:0] imm,
    output logic                  is_branch,
    output logic                  is_jump,
    output logic                  is_jump_reg,
    output logic                  br_kind,
    output decode_pkg::word_t     jump_target
);

    decode_pkg::opcode_e   op;
    decode_pkg::funct_e    fn;
    decode_pkg::reg_addr_t rd;
    decode_pkg::word_t     seq_pc;
    logic is_special;
    logic sa_zero;
    logic inst_addu, inst_subu, inst_slt, inst_sltu;
    logic inst_and, inst_or, inst_xor, inst_nor;
    logic inst_sll, inst_srl, inst_sra, inst_jr;
    logic inst_addiu, inst_andi, inst_ori, inst_lui;
    logic inst_lw, inst_sw, inst_beq, inst_bne, inst_j, inst_jal;
    logic r_arith, shift_op, dst_is_rt;

    assign op  = decode_pkg::opcode_e'(inst[31:26]);
    assign fn  = decode_pkg::funct_e'(inst[5:0]);
    assign rs  = inst[25:21];
    assign rt  = inst[20:16];
    assign rd  = inst[15:11];
    assign imm = inst[15:0];

    assign is_special = op == decode_pkg::op_special;
    assign sa_zero    = inst[10:6] == 5'd0;

    // r-type arithmetic needs sa zero, shifts need rs zero
    assign inst_addu  = is_special && fn == decode_pkg::fn_addu && sa_zero;
    assign inst_subu  = is_special && fn == decode_pkg::fn_subu && sa_zero;
    assign inst_slt   = is_special && fn == decode_pkg::fn_slt && sa_zero;
    assign inst_sltu  = is_special && fn == decode_pkg::fn_sltu && sa_zero;
    assign inst_and   = is_special && fn == decode_pkg::fn_and && sa_zero;
    assign inst_or    = is_special && fn == decode_pkg::fn_or && sa_zero;
    assign inst_xor   = is_special && fn == decode_pkg::fn_xor && sa_zero;
    assign inst_nor   = is_special && fn == decode_pkg::fn_nor && sa_zero;
    assign inst_sll   = is_special && fn == decode_pkg::fn_sll && rs == 5'd0;
    assign inst_srl   = is_special && fn == decode_pkg::fn_srl && rs == 5'd0;
    assign inst_sra   = is_special && fn == decode_pkg::fn_sra && rs == 5'd0;
    assign inst_jr    = is_special && fn == decode_pkg::fn_jr && inst[20:6] == 15'd0;
    assign inst_addiu = op == decode_pkg::op_addiu;
    assign inst_andi  = op == decode_pkg::op_andi;
    assign inst_ori   = op == decode_pkg::op_ori;
    assign inst_lui   = op == decode_pkg::op_lui && rs == 5'd0;
    assign inst_lw    = op == decode_pkg::op_lw;
    assign inst_sw    = op == decode_pkg::op_sw;
    assign inst_beq   = op == decode_pkg::op_beq;
    assign inst_bne   = op == decode_pkg::op_bne;
    assign inst_j     = op == decode_pkg::op_j;
    assign inst_jal   = op == decode_pkg::op_jal;

    assign r_arith = inst_addu | inst_subu | inst_slt | inst_sltu |
                     inst_and | inst_or | inst_xor | inst_nor;
    assign shift_op = inst_sll | inst_srl | inst_sra;

    assign alu_op = inst_subu ? decode_pkg::alu_sub :
                    inst_slt  ? decode_pkg::alu_slt :
                    inst_sltu ? decode_pkg::alu_sltu :
                    (inst_and | inst_andi) ? decode_pkg::alu_and :
                    (inst_or | inst_ori)   ? decode_pkg::alu_or :
                    inst_xor  ? decode_pkg::alu_xor :
                    inst_nor  ? decode_pkg::alu_nor :
                    inst_sll  ? decode_pkg::alu_sll :
                    inst_srl  ? decode_pkg::alu_srl :
                    inst_sra  ? decode_pkg::alu_sra :
                    inst_lui  ? decode_pkg::alu_lui :
                                decode_pkg::alu_add;

    assign src1_is_sa = shift_op;
    assign src1_is_pc = inst_jal;
    assign src2_sel   = inst_jal ? decode_pkg::src2_8 :
                        (inst_andi | inst_ori) ? decode_pkg::src2_uimm :
                        (inst_addiu | inst_lui | inst_lw | inst_sw) ? decode_pkg::src2_simm :
                        decode_pkg::src2_reg;

    assign mem_read  = inst_lw;
    assign mem_write = inst_sw;

    // anything outside the subset leaves all of these low
    assign gr_we     = r_arith | shift_op | inst_addiu | inst_andi | inst_ori |
                       inst_lui | inst_lw | inst_jal;
    assign dst_is_rt = inst_addiu | inst_andi | inst_ori | inst_lui | inst_lw;
    assign dest      = inst_jal ? decode_pkg::link_reg : dst_is_rt ? rt : rd;

    assign rs_used = r_arith | inst_addiu | inst_andi | inst_ori | inst_lw | inst_sw |
                     inst_beq | inst_bne | inst_jr;
    assign rt_used = r_arith | shift_op | inst_sw | inst_beq | inst_bne;

    assign is_branch   = inst_beq | inst_bne;
    assign br_kind     = inst_bne;
    assign is_jump     = inst_j | inst_jal;
    assign is_jump_reg = inst_jr;

    // j and jal stay inside the 256MB region of the delay slot
    assign seq_pc      = pc + 32'd4;
    assign jump_target = {seq_pc[31:28], inst[25:0], 2'b00};

endmodule

`default_nettype wire

// ==== design/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

    parameter int xlen = 32;
    parameter int reg_w = 5;
    parameter int op_w = 6;
    parameter int imm_w = 16;

    typedef logic [reg_w-1:0] reg_addr_t;
    typedef logic [xlen-1:0] word_t;

    // jal writes its return address here
    parameter reg_addr_t link_reg = 5'd31;

    // primary opcode field, inst[31:26]
    typedef enum logic [op_w-1:0] {
        op_special = 6'h00,
        op_j       = 6'h02,
        op_jal     = 6'h03,
        op_beq     = 6'h04,
        op_bne     = 6'h05,
        op_addiu   = 6'h09,
        op_andi    = 6'h0c,
        op_ori     = 6'h0d,
        op_lui     = 6'h0f,
        op_lw      = 6'h23,
        op_sw      = 6'h2b
    } opcode_e;

    // function field of special, inst[5:0]
    typedef enum logic [op_w-1:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_sra  = 6'h03,
        fn_jr   = 6'h08,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_nor  = 6'h27,
        fn_slt  = 6'h2a,
        fn_sltu = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_lui
    } alu_op_e;

    typedef enum logic [1:0] {
        src2_reg,
        src2_simm,
        src2_uimm,
        src2_8
    } src2_sel_e;

endpackage

`default_nettype wire
